/* board_config.svh */
// Board glue configuration
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Interrupt lines from the NIC core
`define IRQ_COUNT 32

// Cycles each interrupt request is held
`define IRQ_STRETCH 10

// Register stages on asynchronous status pins
`define SYNC_STAGES 2

// Synchronized bundle:
// tx_fault, rx_los, mod_abs, rx_status, scl, sda
`define SYNC_WIDTH 6

`endif

/* board_glue.sv */
// NIC board glue top level
`timescale 1ns/1ps

module board_glue (
    input  logic                zynq_pl_clk,
    input  logic                zynq_pl_reset,

    // Interrupts
    input  board_pkg::irq_vec_t irq_i,
    output board_pkg::irq_vec_t zynq_irq_o,

    // SFP cage and PHY status
    input  logic                sfp_tx_fault_i,
    input  logic                sfp_rx_los_i,
    input  logic                sfp_mod_abs_i,
    input  logic                sfp_rx_status_i,

    // I2C line levels and core requests
    input  logic                i2c_scl_i,
    input  logic                i2c_sda_i,
    input  logic                i2c_scl_o_i,
    input  logic                i2c_scl_t_i,
    input  logic                i2c_sda_o_i,
    input  logic                i2c_sda_t_i,

    // Synchronized status
    output logic                sfp_tx_fault_o,
    output logic                sfp_rx_los_o,
    output logic                sfp_mod_abs_o,
    output logic                i2c_scl_o,
    output logic                i2c_sda_o,
    output logic                sfp_link_led_o,

    // I2C pad drive
    output logic                scl_pad_o,
    output logic                scl_pad_oe_o,
    output logic                sda_pad_o,
    output logic                sda_pad_oe_o
);

    irq_stretcher i_irq_stretcher (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .irq_i         (irq_i),
        .zynq_irq_o    (zynq_irq_o)
    );

    sfp_io i_sfp_io (
        .zynq_pl_clk     (zynq_pl_clk),
        .zynq_pl_reset   (zynq_pl_reset),
        .sfp_tx_fault_i  (sfp_tx_fault_i),
        .sfp_rx_los_i    (sfp_rx_los_i),
        .sfp_mod_abs_i   (sfp_mod_abs_i),
        .sfp_rx_status_i (sfp_rx_status_i),
        .i2c_scl_i       (i2c_scl_i),
        .i2c_sda_i       (i2c_sda_i),
        .i2c_scl_o_i     (i2c_scl_o_i),
        .i2c_scl_t_i     (i2c_scl_t_i),
        .i2c_sda_o_i     (i2c_sda_o_i),
        .i2c_sda_t_i     (i2c_sda_t_i),
        .sfp_tx_fault_o  (sfp_tx_fault_o),
        .sfp_rx_los_o    (sfp_rx_los_o),
        .sfp_mod_abs_o   (sfp_mod_abs_o),
        .i2c_scl_o       (i2c_scl_o),
        .i2c_sda_o       (i2c_sda_o),
        .sfp_link_led_o  (sfp_link_led_o),
        .scl_pad_o       (scl_pad_o),
        .scl_pad_oe_o    (scl_pad_oe_o),
        .sda_pad_o       (sda_pad_o),
        .sda_pad_oe_o    (sda_pad_oe_o)
    );

endmodule

/* board_glue_checker.sv */
// Board glue output checker
`timescale 1ns/1ps
`include "board_config.svh"

module board_glue_checker (
    input  logic                zynq_pl_clk,
    input  logic                zynq_pl_reset,
    input  board_pkg::irq_vec_t irq_i,
    input  board_pkg::irq_vec_t zynq_irq_o,
    input  logic                sfp_tx_fault_i,
    input  logic                sfp_rx_los_i,
    input  logic                sfp_mod_abs_i,
    input  logic                sfp_rx_status_i,
    input  logic                i2c_scl_o_i,
    input  logic                i2c_scl_t_i,
    input  logic                i2c_sda_o_i,
    input  logic                i2c_sda_t_i,
    input  logic                sfp_tx_fault_o,
    input  logic                sfp_rx_los_o,
    input  logic                sfp_mod_abs_o,
    input  logic                i2c_scl_o,
    input  logic                i2c_sda_o,
    input  logic                sfp_link_led_o,
    input  logic                scl_pad_o,
    input  logic                scl_pad_oe_o,
    input  logic                sda_pad_o,
    input  logic                sda_pad_oe_o,
    output int                  check_count,
    output int                  error_count
);

    // Remaining hold cycles per interrupt line
    int hold_cnt [`IRQ_COUNT];
    board_pkg::irq_vec_t exp_irq;

    // Status samples one and two edges old
    board_pkg::sync_vec_t status_d1;
    board_pkg::sync_vec_t status_d2;

    logic scl_val_m;
    logic sda_val_m;
    logic scl_rel_m;
    logic sda_rel_m;
    logic scl_line_m;
    logic sda_line_m;
    logic model_valid = 1'b0;
    int   checks = 0;
    int   errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    // Pull-up holds the line high unless the modeled pad drives it
    assign scl_line_m = scl_rel_m ? 1'b1 : scl_val_m;
    assign sda_line_m = sda_rel_m ? 1'b1 : sda_val_m;

    always @(posedge zynq_pl_clk) begin
        // A new high sample reloads the full window
        for (int k = 0; k < `IRQ_COUNT; k++) begin
            if (zynq_pl_reset) begin
                hold_cnt[k] <= 0;
            end else if (irq_i[k]) begin
                hold_cnt[k] <= `IRQ_STRETCH;
            end else if (hold_cnt[k] > 0) begin
                hold_cnt[k] <= hold_cnt[k] - 1;
            end
        end
        if (zynq_pl_reset) begin
            status_d1   <= '0;
            status_d2   <= '0;
            scl_rel_m   <= 1'b1;
            sda_rel_m   <= 1'b1;
            model_valid <= 1'b1;
        end else begin
            status_d1 <= {sfp_tx_fault_i, sfp_rx_los_i, sfp_mod_abs_i,
                          sfp_rx_status_i, scl_line_m, sda_line_m};
            status_d2 <= status_d1;
            scl_rel_m <= i2c_scl_t_i;
            sda_rel_m <= i2c_sda_t_i;
        end
        scl_val_m <= i2c_scl_o_i;
        sda_val_m <= i2c_sda_o_i;
    end

    always_comb begin
        for (int k = 0; k < `IRQ_COUNT; k++) begin
            exp_irq[k] = (hold_cnt[k] != 0);
        end
    end

    task automatic compare_vec(input string test, input string sig,
                               input board_pkg::irq_vec_t exp,
                               input board_pkg::irq_vec_t act);
        string name;
        if (zynq_pl_reset) begin
            name = "reset_values";
        end else begin
            name = test;
        end
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: %s expected %h actual %h at %0t",
                     name, sig, exp, act, $time);
        end
    endtask

    task automatic compare_bit(input string test, input string sig,
                               input logic exp, input logic act);
        string name;
        if (zynq_pl_reset) begin
            name = "reset_values";
        end else begin
            name = test;
        end
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: %s expected %b actual %b at %0t",
                     name, sig, exp, act, $time);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge zynq_pl_clk) begin
        if (model_valid) begin
            compare_vec("irq_stretch", "zynq_irq_o", exp_irq, zynq_irq_o);
            compare_bit("status_sync", "sfp_tx_fault_o", status_d2[5], sfp_tx_fault_o);
            compare_bit("status_sync", "sfp_rx_los_o", status_d2[4], sfp_rx_los_o);
            compare_bit("status_sync", "sfp_mod_abs_o", status_d2[3], sfp_mod_abs_o);
            compare_bit("link_led", "sfp_link_led_o", status_d2[2], sfp_link_led_o);
            compare_bit("i2c_readback", "i2c_scl_o", status_d2[1], i2c_scl_o);
            compare_bit("i2c_readback", "i2c_sda_o", status_d2[0], i2c_sda_o);
            compare_bit("i2c_pad", "scl_pad_oe_o", ~scl_rel_m, scl_pad_oe_o);
            compare_bit("i2c_pad", "sda_pad_oe_o", ~sda_rel_m, sda_pad_oe_o);
            compare_bit("i2c_pad", "scl_pad_o", scl_val_m, scl_pad_o);
            compare_bit("i2c_pad", "sda_pad_o", sda_val_m, sda_pad_o);
        end
    end

endmodule

/* board_glue_input.txt */
# irq_hex tx_fault rx_los mod_abs rx_status scl_o scl_t sda_o sda_t
# One line per clock cycle, a t bit of 1 releases the line
# Single pulse on line 0
00000001 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
# Status pins toggle while line 5 is retriggered, lines 31 and 16 stand alone
00000020 1 0 0 1 1 1 1 1
00000000 1 1 0 1 1 1 1 1
00000000 0 1 1 1 1 1 1 1
00000000 0 0 1 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000020 0 0 0 1 1 1 1 1
80000000 0 0 0 1 1 1 1 1
00000000 0 0 0 1 1 1 1 1
00010000 0 0 0 0 1 1 1 1
# I2C drives scl and sda low, then releases them
00000000 0 0 0 0 0 0 1 1
00000000 0 0 0 0 0 0 0 0
00000000 0 0 0 0 1 1 0 0
00000000 0 0 0 0 1 1 1 1
00000000 1 1 1 1 0 1 0 1
00000000 0 0 0 0 1 0 1 0
00000000 0 0 0 0 1 1 1 1
# Idle tail lets every window expire
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1
00000000 0 0 0 0 1 1 1 1

/* board_pkg.sv */
// Board glue types
`include "board_config.svh"

package board_pkg;

    // One bit per interrupt line
    typedef logic [`IRQ_COUNT-1:0] irq_vec_t;

    // Synchronized status bundle, MSB first:
    // tx_fault, rx_los, mod_abs, rx_status, scl, sda
    typedef logic [`SYNC_WIDTH-1:0] sync_vec_t;

endpackage

/* irq_stretcher.sv */
// Interrupt pulse stretcher
`timescale 1ns/1ps
`include "board_config.svh"

module irq_stretcher (
    input  logic                zynq_pl_clk,
    input  logic                zynq_pl_reset,
    input  board_pkg::irq_vec_t irq_i,
    output board_pkg::irq_vec_t zynq_irq_o
);

    // Sample history, newest sample in entry 0
    board_pkg::irq_vec_t [`IRQ_STRETCH-1:0] irq_hist;

    board_pkg::irq_vec_t irq_held;

    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            irq_hist <= '0;
        end else begin
            irq_hist <= {irq_hist[`IRQ_STRETCH-2:0], irq_i};
        end
    end

    // A line stays up while any of its last samples was high,
    // so a new pulse restarts the window for that line only
    always_comb begin
        irq_held = '0;
        for (int i = 0; i < `IRQ_STRETCH; i++) begin
            irq_held = irq_held | irq_hist[i];
        end
    end

    assign zynq_irq_o = irq_held;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the board glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_EXE=sim_board_glue

verilator --binary --timing --timescale 1ns/1ps \
    -f verilog.f \
    --top-module tb_board_glue \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

/* sfp_io.sv */
// SFP status and I2C pad logic
`timescale 1ns/1ps
`include "board_config.svh"

module sfp_io (
    input  logic zynq_pl_clk,
    input  logic zynq_pl_reset,

    // Asynchronous status pins
    input  logic sfp_tx_fault_i,
    input  logic sfp_rx_los_i,
    input  logic sfp_mod_abs_i,
    input  logic sfp_rx_status_i,

    // Resolved I2C line levels
    input  logic i2c_scl_i,
    input  logic i2c_sda_i,

    // Core drive value and release request
    input  logic i2c_scl_o_i,
    input  logic i2c_scl_t_i,
    input  logic i2c_sda_o_i,
    input  logic i2c_sda_t_i,

    output logic sfp_tx_fault_o,
    output logic sfp_rx_los_o,
    output logic sfp_mod_abs_o,
    output logic i2c_scl_o,
    output logic i2c_sda_o,
    output logic sfp_link_led_o,

    output logic scl_pad_o,
    output logic scl_pad_oe_o,
    output logic sda_pad_o,
    output logic sda_pad_oe_o
);

    board_pkg::sync_vec_t                    sync_in;
    board_pkg::sync_vec_t [`SYNC_STAGES-1:0] sync_stage;
    board_pkg::sync_vec_t                    sync_out;

    // Pad registers, bit 1 is scl and bit 0 is sda
    logic [1:0] pad_val_q;
    logic [1:0] pad_rel_q;

    assign sync_in = {sfp_tx_fault_i, sfp_rx_los_i, sfp_mod_abs_i,
                      sfp_rx_status_i, i2c_scl_i, i2c_sda_i};

    // Stage 0 samples the pins, last stage feeds the outputs
    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            sync_stage <= '0;
        end else begin
            sync_stage <= {sync_stage[`SYNC_STAGES-2:0], sync_in};
        end
    end

    assign sync_out = sync_stage[`SYNC_STAGES-1];

    assign sfp_tx_fault_o = sync_out[5];
    assign sfp_rx_los_o   = sync_out[4];
    assign sfp_mod_abs_o  = sync_out[3];
    assign i2c_scl_o      = sync_out[1];
    assign i2c_sda_o      = sync_out[0];

    // Link LED lit by PHY rx status
    assign sfp_link_led_o = sync_out[2];

    // Both lines released out of reset
    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            pad_rel_q <= 2'b11;
        end else begin
            pad_rel_q <= {i2c_scl_t_i, i2c_sda_t_i};
        end
    end

    always_ff @(posedge zynq_pl_clk) begin
        pad_val_q <= {i2c_scl_o_i, i2c_sda_o_i};
    end

    // Open drain, the pull-up takes the line when released
    assign scl_pad_o    = pad_val_q[1];
    assign sda_pad_o    = pad_val_q[0];
    assign scl_pad_oe_o = ~pad_rel_q[1];
    assign sda_pad_oe_o = ~pad_rel_q[0];

endmodule

/* tb_board_glue.sv */
// Board glue testbench
`timescale 1ns/1ps
`include "board_config.svh"

module tb_board_glue;

    localparam int    RESET_CYCLES  = 16;
    localparam int    RESET_TIMEOUT = 100;
    localparam int    MAX_CYCLES    = 2000;
    localparam int    DRAIN_CYCLES  = `IRQ_STRETCH + 4;
    localparam string INPUT_FILE    = "board_glue_input.txt";

    logic                zynq_pl_clk;
    logic                zynq_pl_reset = 1'b1;
    board_pkg::irq_vec_t irq_i;
    board_pkg::irq_vec_t zynq_irq_o;
    logic                sfp_tx_fault_i;
    logic                sfp_rx_los_i;
    logic                sfp_mod_abs_i;
    logic                sfp_rx_status_i;
    logic                i2c_scl_i;
    logic                i2c_sda_i;
    logic                i2c_scl_o_i;
    logic                i2c_scl_t_i;
    logic                i2c_sda_o_i;
    logic                i2c_sda_t_i;
    logic                sfp_tx_fault_o;
    logic                sfp_rx_los_o;
    logic                sfp_mod_abs_o;
    logic                i2c_scl_o;
    logic                i2c_sda_o;
    logic                sfp_link_led_o;
    logic                scl_pad_o;
    logic                scl_pad_oe_o;
    logic                sda_pad_o;
    logic                sda_pad_oe_o;
    int                  check_count;
    int                  error_count;
    int                  other_errors = 0;

    // Pull-up takes each line unless its pad enable is high
    assign i2c_scl_i = (scl_pad_oe_o === 1'b1) ? scl_pad_o : 1'b1;
    assign i2c_sda_i = (sda_pad_oe_o === 1'b1) ? sda_pad_o : 1'b1;

    board_glue i_board_glue (.*);

    board_glue_checker i_checker (.*);

    initial begin
        zynq_pl_clk = 1'b0;
        forever #2 zynq_pl_clk = ~zynq_pl_clk;
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge zynq_pl_clk);
        #1;
        zynq_pl_reset = 1'b0;
    end

    initial begin
        int    fd;
        int    cycles;
        int    fields;
        string line;

        irq_i           = '0;
        sfp_tx_fault_i  = 1'b0;
        sfp_rx_los_i    = 1'b0;
        sfp_mod_abs_i   = 1'b0;
        sfp_rx_status_i = 1'b0;
        i2c_scl_o_i     = 1'b1;
        i2c_scl_t_i     = 1'b1;
        i2c_sda_o_i     = 1'b1;
        i2c_sda_t_i     = 1'b1;

        cycles = 0;
        while (zynq_pl_reset === 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge zynq_pl_clk);
            cycles++;
        end
        if (zynq_pl_reset !== 1'b0) begin
            $display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
            other_errors++;
        end

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %s", INPUT_FILE);
            other_errors++;
        end else begin
            cycles = 0;
            while (!$feof(fd) && cycles < MAX_CYCLES) begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines take no cycle
                if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    @(posedge zynq_pl_clk);
                    #1;
                    fields = $sscanf(line, "%h %b %b %b %b %b %b %b %b", irq_i,
                                     sfp_tx_fault_i, sfp_rx_los_i, sfp_mod_abs_i,
                                     sfp_rx_status_i, i2c_scl_o_i, i2c_scl_t_i,
                                     i2c_sda_o_i, i2c_sda_t_i);
                    if (fields != 9) begin
                        $display("Stimulus line could not be parsed: %s", line);
                        other_errors++;
                    end
                    cycles++;
                end
            end
            if (cycles >= MAX_CYCLES) begin
                $display("Timeout: stimulus not finished after %0d cycles", MAX_CYCLES);
                other_errors++;
            end
            $fclose(fd);
        end

        // Let the longest interrupt window run out
        cycles = 0;
        while (cycles < DRAIN_CYCLES) begin
            @(posedge zynq_pl_clk);
            cycles++;
        end
        @(negedge zynq_pl_clk);
        #1;

        $display("Checks: %0d, value mismatches: %0d, other errors: %0d",
                 check_count, error_count, other_errors);
        if (error_count == 0 && other_errors == 0 && check_count > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
board_pkg.sv
irq_stretcher.sv
sfp_io.sv
board_glue.sv
board_glue_checker.sv
tb_board_glue.sv
